/* compile.f */
pointPoolPkg.sv
featureBuffer.sv
poolCore.sv
pointDispatcher.sv
resultCollector.sv
pointPool.sv
pointPool_props.sv
pointPool_tb.sv

/* pointPool_tb.sv */
`timescale 1ns/100ps
// Self-checking testbench for the pooling top level; loads features, sends map words, checks results
module pointPool_tb;

    localparam int numCore   = 4;
    localparam int loadWords = 5 * pointPoolPkg::bufferDepth;
    localparam int mapWords  = 24 + 24 + 10 + 8 + 8;
    localparam int cycleLimit = (loadWords + mapWords * 12) * 2;

    logic                    clk;
    logic                    reset;
    pointPoolPkg::streamWord inDat;
    logic                    inDatVld;
    logic                    inDatLast;
    logic                    inDatRdy;
    pointPoolPkg::streamWord outDat;
    logic                    outDatVld;
    logic                    outDatLast;
    logic                    outDatRdy;

    logic [63:0] featMem [pointPoolPkg::bufferDepth];
    // Expected results in map-word order, last flag on top
    logic [64:0] expQ [$];
    logic [31:0] stimState = 32'h61e8;
    logic [31:0] rdyState  = 32'h61e8;
    logic        rdyRandom = 1'b0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          recvCount  = 0;
    int          cycleCount = 0;

    pointPool #(
        .numCore    ( numCore    )
    ) UUT (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .inDat      ( inDat      ),
        .inDatVld   ( inDatVld   ),
        .inDatLast  ( inDatLast  ),
        .inDatRdy   ( inDatRdy   ),
        .outDat     ( outDat     ),
        .outDatVld  ( outDatVld  ),
        .outDatLast ( outDatLast ),
        .outDatRdy  ( outDatRdy  )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ================================================
    // Random numbers and reference model
    // ================================================
    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] nextRand();
        stimState = lcgNext(stimState);
        return stimState;
    endfunction

    function automatic logic [63:0] randWord();
        logic [63:0] w;
        w[63:32] = nextRand();
        w[31:0]  = nextRand();
        return w;
    endfunction

    // Count 1 to 7, indices inside the buffer
    function automatic logic [63:0] randomMap();
        logic [63:0] w;
        logic [31:0] r;
        r = nextRand();
        w = '0;
        w[63:56] = 8'(1 + r % 7);
        for (int n = 0; n < 7; n++) begin
            r = nextRand();
            w[n*8 +: 8] = 8'(r[21:16]);
        end
        return w;
    endfunction

    function automatic logic [63:0] maxPool(input logic [63:0] mapW);
        logic [63:0] result;
        logic [7:0]  feat;
        int          cnt;
        int          addr;
        result = '0;
        cnt = mapW[63:56];
        if (cnt > 7) begin
            cnt = 7;
        end
        for (int n = 0; n < cnt; n++) begin
            addr = mapW[n*8 +: 8] % pointPoolPkg::bufferDepth;
            for (int ch = 0; ch < 8; ch++) begin
                feat = featMem[addr][ch*8 +: 8];
                if (feat > result[ch*8 +: 8]) begin
                    result[ch*8 +: 8] = feat;
                end
            end
        end
        return result;
    endfunction

    // ================================================
    // Checks and stimulus tasks
    // ================================================
    task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Called at a falling edge, returns at the falling edge after the transfer
    task automatic sendWord(input logic [63:0] word, input logic last);
        inDat     = word;
        inDatVld  = 1'b1;
        inDatLast = last;
        while (!inDatRdy) @(negedge clk);
        @(negedge clk);
        inDatVld  = 1'b0;
        inDatLast = 1'b0;
    endtask

    task automatic loadFeatures();
        for (int n = 0; n < pointPoolPkg::bufferDepth; n++) begin
            featMem[n] = randWord();
            sendWord(featMem[n], n == pointPoolPkg::bufferDepth - 1);
        end
    endtask

    task automatic sendMap(input logic [63:0] word, input logic last);
        expQ.push_back({last, maxPool(word)});
        sendWord(word, last);
    endtask

    task automatic awaitResults(input int sent, input int recvBefore);
        while (expQ.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        checkValue("result count", 64'(recvCount - recvBefore), 64'(sent));
    endtask

    task automatic runRandom(input int numMaps);
        int recvBefore;
        recvBefore = recvCount;
        loadFeatures();
        for (int m = 0; m < numMaps; m++) begin
            sendMap(randomMap(), m == numMaps - 1);
        end
        awaitResults(numMaps, recvBefore);
    endtask

    task automatic reportTest(input int num, input string name, input int errBefore);
        $display("Test %0d %s done, %0d errors", num, name, errorCount - errBefore);
    endtask

    // ================================================
    // Output side
    // ================================================
    initial begin : readyDriver
        forever begin
            @(negedge clk);
            rdyState  = lcgNext(rdyState);
            outDatRdy = rdyRandom ? rdyState[16] : 1'b1;
        end
    end

    initial begin : outputMonitor
        logic [64:0] expWord;
        forever begin
            @(posedge clk);
            if (!reset && outDatVld && outDatRdy) begin
                recvCount++;
                if (expQ.size() == 0) begin
                    errorCount++;
                    $display("Output word %h arrived with no result expected", outDat);
                end else begin
                    expWord = expQ.pop_front();
                    checkValue("outDat", outDat, expWord[63:0]);
                    checkValue("outDatLast", 64'(outDatLast), 64'(expWord[64]));
                end
            end
        end
    end

    initial begin : watchdog
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run timed out after %0d cycles, %0d results missing", cycleCount, expQ.size());
        $display("Checks failed");
        $finish;
    end

    // ================================================
    // Test sequence
    // ================================================
    initial begin : mainFlow
        logic [63:0] edgeMap [10];
        logic [63:0] raw;
        int          errBefore;
        int          recvBefore;
        reset     = 1'b1;
        inDat     = '0;
        inDatVld  = 1'b0;
        inDatLast = 1'b0;
        outDatRdy = 1'b0;
        errBefore = errorCount;
        repeat (5) @(posedge clk);
        @(negedge clk);
        // Input side stays closed while reset is held
        checkValue("inDatRdy", 64'(inDatRdy), 64'h0);
        reset = 1'b0;

        repeat (20) begin
            @(negedge clk);
            checkValue("outDatVld", 64'(outDatVld), 64'h0);
        end
        reportTest(1, "idle after reset", errBefore);

        errBefore = errorCount;
        runRandom(24);
        reportTest(2, "full output rate", errBefore);

        errBefore = errorCount;
        rdyRandom = 1'b1;
        runRandom(24);
        rdyRandom = 1'b0;
        reportTest(3, "output back-pressure", errBefore);

        // Zero, clamped and wrapped counts, plus repeated indices
        errBefore = errorCount;
        recvBefore = recvCount;
        loadFeatures();
        raw = randWord();
        edgeMap[0] = {8'd0, raw[55:0]};
        raw = randWord();
        edgeMap[1] = {8'd8, raw[55:0]};
        raw = randWord();
        edgeMap[2] = {8'hff, raw[55:0]};
        edgeMap[3] = {8'd7, 8'd191, 8'd255, 8'd200, 8'd128, 8'd127, 8'd65, 8'd64};
        edgeMap[4] = {8'd3, 8'd0, 8'd0, 8'd0, 8'd0, 8'd9, 8'd5, 8'd3};
        edgeMap[5] = {8'd7, 8'd9, 8'd9, 8'd5, 8'd5, 8'd3, 8'd3, 8'd3};
        edgeMap[6] = {8'd7, {7{8'd12}}};
        edgeMap[7] = {8'd1, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd76};
        raw = randWord();
        edgeMap[8] = {8'd200, raw[55:0]};
        raw = randWord();
        edgeMap[9] = {8'd0, raw[55:0]};
        for (int m = 0; m < 10; m++) begin
            sendMap(edgeMap[m], m == 9);
        end
        awaitResults(10, recvBefore);
        reportTest(4, "edge counts and indices", errBefore);

        errBefore = errorCount;
        runRandom(8);
        runRandom(8);
        reportTest(5, "last flag and reload", errBefore);

        $display("Summary: %0d checks, %0d errors, %0d results", checkCount, errorCount, recvCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* pointPool_props.sv */
`timescale 1ns/100ps
// Handshake and read arbitration assertions, attached to the pooling top level through bind
module pointPoolProps #(
    parameter int numCore = 4
) (
    input logic                              clk,
    input logic                              reset,
    input logic                              inDatVld,
    input logic                              inDatLast,
    input logic                              inDatRdy,
    input logic [pointPoolPkg::wordWidth-1:0] outDat,
    input logic                              outDatVld,
    input logic                              outDatLast,
    input logic                              outDatRdy,
    input logic [numCore-1:0]                coreBusy,
    input logic [numCore-1:0]                rdReq,
    input logic [numCore-1:0]                rdGnt,
    input logic [numCore-1:0]                rdDatVld
);

    // Stream phase as seen from outside
    logic inMap;
    // Set by a run's last map word, cleared once every core is idle
    logic waitIdle;

    always_ff @(posedge clk) begin
        if (reset) begin
            inMap    <= 1'b0;
            waitIdle <= 1'b0;
        end else if (inDatVld && inDatRdy && inDatLast) begin
            inMap <= ~inMap;
            if (inMap) begin
                waitIdle <= 1'b1;
            end
        end else if (waitIdle && !(|coreBusy)) begin
            waitIdle <= 1'b0;
        end
    end

    aOutHold: assert property (@(posedge clk) disable iff (reset)
        (outDatVld && !outDatRdy) |=> (outDatVld && $stable(outDat) && $stable(outDatLast)))
        else $error("Output word or last flag changed while waiting for ready");

    aVldOneHot: assert property (@(posedge clk) disable iff (reset) $onehot0(rdDatVld))
        else $error("More than one read data valid at once");

    // Data valid only for a core that requested and won the previous cycle
    aVldAfterGnt: assert property (@(posedge clk) disable iff (reset)
        rdDatVld == $past(rdGnt & rdReq))
        else $error("Read data valid does not follow a granted request by one cycle");

    aDrainStall: assert property (@(posedge clk) disable iff (reset)
        (waitIdle && (|coreBusy)) |-> !inDatRdy)
        else $error("Input ready high while cores still busy after a run");

endmodule

bind pointPool pointPoolProps #(
    .numCore    ( numCore    )
) uProps (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .inDatVld   ( inDatVld   ),
    .inDatLast  ( inDatLast  ),
    .inDatRdy   ( inDatRdy   ),
    .outDat     ( outDat     ),
    .outDatVld  ( outDatVld  ),
    .outDatLast ( outDatLast ),
    .outDatRdy  ( outDatRdy  ),
    .coreBusy   ( coreBusy   ),
    .rdReq      ( rdReq      ),
    .rdGnt      ( rdGnt      ),
    .rdDatVld   ( rdDatVld   )
);

/* pointPool.sv */
`timescale 1ns/100ps
// Top level of the pooling path; connects dispatcher, feature buffer, pool cores and collector
module pointPool #(
    parameter int numCore = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  pointPoolPkg::streamWord inDat,
    input  logic                    inDatVld,
    input  logic                    inDatLast,
    output logic                    inDatRdy,
    output pointPoolPkg::streamWord outDat,
    output logic                    outDatVld,
    output logic                    outDatLast,
    input  logic                    outDatRdy
);

    // ================================================
    // Internal wires
    // ================================================
    // Buffer write port
    logic                                     wrEn;
    logic [pointPoolPkg::bufferAddrWidth-1:0] wrAddr;
    pointPoolPkg::streamWord                  wrDat;

    // Map distribution
    pointPoolPkg::streamWord mapWord;
    logic                    mapLast;
    logic [numCore-1:0]      coreStart;
    logic [numCore-1:0]      coreBusy;

    // Shared buffer read port
    logic [numCore-1:0]                                    rdReq;
    logic [numCore-1:0][pointPoolPkg::bufferAddrWidth-1:0] rdAddr;
    logic [numCore-1:0]                                    rdGnt;
    pointPoolPkg::streamWord                               rdDat;
    logic [numCore-1:0]                                    rdDatVld;

    // Finished results
    logic [numCore-1:0]                    resDone;
    pointPoolPkg::streamWord [numCore-1:0] resDat;
    logic [numCore-1:0]                    resLast;
    logic [numCore-1:0]                    resTake;

    // ================================================
    // Sub-modules
    // ================================================
    pointDispatcher #(
        .numCore   ( numCore   )
    ) uDispatcher (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .inDat     ( inDat     ),
        .inDatVld  ( inDatVld  ),
        .inDatLast ( inDatLast ),
        .inDatRdy  ( inDatRdy  ),
        .wrEn      ( wrEn      ),
        .wrAddr    ( wrAddr    ),
        .wrDat     ( wrDat     ),
        .mapWord   ( mapWord   ),
        .mapLast   ( mapLast   ),
        .coreStart ( coreStart ),
        .coreBusy  ( coreBusy  )
    );

    featureBuffer #(
        .numCore  ( numCore  )
    ) uFeatureBuffer (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .wrEn     ( wrEn     ),
        .wrAddr   ( wrAddr   ),
        .wrDat    ( wrDat    ),
        .rdReq    ( rdReq    ),
        .rdAddr   ( rdAddr   ),
        .rdGnt    ( rdGnt    ),
        .rdDat    ( rdDat    ),
        .rdDatVld ( rdDatVld )
    );

    for (genvar c = 0; c < numCore; c++) begin : genCore
        poolCore uPoolCore (
            .clk       ( clk          ),
            .reset     ( reset        ),
            .coreStart ( coreStart[c] ),
            .mapWord   ( mapWord      ),
            .mapLast   ( mapLast      ),
            .coreBusy  ( coreBusy[c]  ),
            .rdReq     ( rdReq[c]     ),
            .rdAddr    ( rdAddr[c]    ),
            .rdGnt     ( rdGnt[c]     ),
            .rdDat     ( rdDat        ),
            .rdDatVld  ( rdDatVld[c]  ),
            .resDone   ( resDone[c]   ),
            .resDat    ( resDat[c]    ),
            .resLast   ( resLast[c]   ),
            .resTake   ( resTake[c]   )
        );
    end

    resultCollector #(
        .numCore    ( numCore    )
    ) uCollector (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .resDone    ( resDone    ),
        .resDat     ( resDat     ),
        .resLast    ( resLast    ),
        .resTake    ( resTake    ),
        .outDat     ( outDat     ),
        .outDatVld  ( outDatVld  ),
        .outDatLast ( outDatLast ),
        .outDatRdy  ( outDatRdy  )
    );

endmodule

/* resultCollector.sv */
`timescale 1ns/100ps
// Output side; drains finished pool cores in dispatch order onto the output stream
module resultCollector #(
    parameter int numCore = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [numCore-1:0]                    resDone,
    input  pointPoolPkg::streamWord [numCore-1:0] resDat,
    input  logic [numCore-1:0]                    resLast,
    output logic [numCore-1:0]                    resTake,
    output pointPoolPkg::streamWord               outDat,
    output logic                                  outDatVld,
    output logic                                  outDatLast,
    input  logic                                  outDatRdy
);

    localparam int ptrWidth = pointPoolPkg::corePtrWidth(numCore);

    // Next core in dispatch order
    logic [ptrWidth-1:0] takePtr;
    logic                outFire;

    // ================================================
    // Output stream
    // ================================================
    // Only the expected core may present, so order follows the map words
    assign outDatVld  = resDone[takePtr];
    assign outDatLast = resDone[takePtr] & resLast[takePtr];
    assign outDat     = resDat[takePtr];
    assign outFire    = outDatVld & outDatRdy;

    always_comb begin
        resTake          = '0;
        resTake[takePtr] = outFire;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            takePtr <= '0;
        end else if (outFire) begin
            takePtr <= (takePtr == ptrWidth'(numCore - 1)) ? '0 : takePtr + 1'b1;
        end
    end

endmodule

/* pointDispatcher.sv */
`timescale 1ns/100ps
// Input stream phase control; loads features into the buffer, then starts pool cores with map words
module pointDispatcher #(
    parameter int numCore = 4
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  pointPoolPkg::streamWord                  inDat,
    input  logic                                     inDatVld,
    input  logic                                     inDatLast,
    output logic                                     inDatRdy,
    output logic                                     wrEn,
    output logic [pointPoolPkg::bufferAddrWidth-1:0] wrAddr,
    output pointPoolPkg::streamWord                  wrDat,
    output pointPoolPkg::streamWord                  mapWord,
    output logic                                     mapLast,
    output logic [numCore-1:0]                       coreStart,
    input  logic [numCore-1:0]                       coreBusy
);

    localparam int ptrWidth = pointPoolPkg::corePtrWidth(numCore);
    localparam logic [pointPoolPkg::countWidth-1:0] countMax =
        pointPoolPkg::countWidth'(pointPoolPkg::maxNeighbor);

    // Phase encoding
    localparam logic [1:0] phaseLoad  = 2'd0;
    localparam logic [1:0] phaseMap   = 2'd1;
    localparam logic [1:0] phaseDrain = 2'd2;

    logic [1:0]          phase;
    logic [ptrWidth-1:0] corePtr;
    logic                inFire;

    // ================================================
    // Handshake
    // ================================================
    // Map words wait for the target core; nothing is taken while draining
    always_comb begin
        case (phase)
            phaseLoad: inDatRdy = ~|coreBusy;
            phaseMap:  inDatRdy = ~coreBusy[corePtr];
            default:   inDatRdy = 1'b0;
        endcase
    end

    assign inFire = inDatVld & inDatRdy;

    // Feature words go straight to the buffer
    assign wrEn  = inFire & (phase == phaseLoad);
    assign wrDat = inDat;

    // Map view, with the neighbor count clamped
    always_comb begin
        mapWord = inDat;
        if (inDat.map.count > countMax) begin
            mapWord.map.count = countMax;
        end
    end

    assign mapLast = inDatLast;

    always_comb begin
        coreStart = '0;
        if (inFire && phase == phaseMap) begin
            coreStart[corePtr] = 1'b1;
        end
    end

    // ================================================
    // Phase, write address and core pointer
    // ================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            // Leaves through the drain check, so loading starts once cores are seen idle
            phase   <= phaseDrain;
            wrAddr  <= '0;
            corePtr <= '0;
        end else begin
            case (phase)
                phaseLoad: begin
                    if (inFire) begin
                        wrAddr <= wrAddr + 1'b1;
                        if (inDatLast) begin
                            phase <= phaseMap;
                        end
                    end
                end
                phaseMap: begin
                    if (inFire) begin
                        corePtr <= (corePtr == ptrWidth'(numCore - 1)) ? '0 : corePtr + 1'b1;
                        if (inDatLast) begin
                            phase <= phaseDrain;
                        end
                    end
                end
                default: begin
                    if (!(|coreBusy)) begin
                        phase  <= phaseLoad;
                        wrAddr <= '0;
                    end
                end
            endcase
        end
    end

endmodule

/* poolCore.sv */
`timescale 1ns/100ps
// One pool core; reads the neighbors named by a map word and keeps their channel-wise maximum
module poolCore (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     coreStart,
    input  pointPoolPkg::streamWord                  mapWord,
    input  logic                                     mapLast,
    output logic                                     coreBusy,
    output logic                                     rdReq,
    output logic [pointPoolPkg::bufferAddrWidth-1:0] rdAddr,
    input  logic                                     rdGnt,
    input  pointPoolPkg::streamWord                  rdDat,
    input  logic                                     rdDatVld,
    output logic                                     resDone,
    output pointPoolPkg::streamWord                  resDat,
    output logic                                     resLast,
    input  logic                                     resTake
);

    localparam int cntWidth = $clog2(pointPoolPkg::maxNeighbor + 1);

    // Pending indices, next one always in slot 0
    logic [pointPoolPkg::maxNeighbor-1:0][pointPoolPkg::idxWidth-1:0] idxQueue;

    logic [cntWidth-1:0]     needCnt;
    logic [cntWidth-1:0]     issueCnt;
    logic [cntWidth-1:0]     recvCnt;
    logic                    busy;
    pointPoolPkg::streamWord maxAcc;

    assign coreBusy = busy;
    assign rdReq    = busy & (issueCnt != needCnt);
    // Low bits only, so indices wrap at the buffer depth
    assign rdAddr   = idxQueue[0][pointPoolPkg::bufferAddrWidth-1:0];
    assign resDat   = maxAcc;

    // ================================================
    // Control
    // ================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            resDone  <= 1'b0;
            resLast  <= 1'b0;
            needCnt  <= '0;
            issueCnt <= '0;
            recvCnt  <= '0;
        end else if (coreStart) begin
            busy     <= 1'b1;
            resDone  <= 1'b0;
            resLast  <= mapLast;
            // Count arrives already clamped to maxNeighbor
            needCnt  <= mapWord.map.count[cntWidth-1:0];
            issueCnt <= '0;
            recvCnt  <= '0;
        end else if (resTake) begin
            busy    <= 1'b0;
            resDone <= 1'b0;
        end else if (busy) begin
            if (rdGnt) begin
                issueCnt <= issueCnt + 1'b1;
            end
            if (rdDatVld) begin
                recvCnt <= recvCnt + 1'b1;
            end
            // All reads back, nothing outstanding
            if (!resDone && recvCnt == needCnt) begin
                resDone <= 1'b1;
            end
        end
    end

    // ================================================
    // Index queue and running maximum
    // ================================================
    always_ff @(posedge clk) begin
        if (coreStart) begin
            idxQueue <= mapWord.map.index;
            maxAcc   <= '0;
        end else begin
            if (rdGnt) begin
                idxQueue <= idxQueue >> pointPoolPkg::idxWidth;
            end
            if (rdDatVld) begin
                for (int ch = 0; ch < pointPoolPkg::numChannel; ch++) begin
                    if (rdDat.feature[ch] > maxAcc.feature[ch]) begin
                        maxAcc.feature[ch] <= rdDat.feature[ch];
                    end
                end
            end
        end
    end

endmodule

/* featureBuffer.sv */
`timescale 1ns/100ps
// Point feature memory; one write port from the dispatcher, one read port shared by the pool cores
module featureBuffer #(
    parameter int numCore = 4
) (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  wrEn,
    input  logic [pointPoolPkg::bufferAddrWidth-1:0]              wrAddr,
    input  pointPoolPkg::streamWord                               wrDat,
    input  logic [numCore-1:0]                                    rdReq,
    input  logic [numCore-1:0][pointPoolPkg::bufferAddrWidth-1:0] rdAddr,
    output logic [numCore-1:0]                                    rdGnt,
    output pointPoolPkg::streamWord                               rdDat,
    output logic [numCore-1:0]                                    rdDatVld
);

    localparam int ptrWidth = pointPoolPkg::corePtrWidth(numCore);

    pointPoolPkg::streamWord mem [pointPoolPkg::bufferDepth];

    logic [ptrWidth-1:0] gntPtr;
    logic [ptrWidth-1:0] gntIdx;
    logic                gntAny;

    // ================================================
    // Round-robin arbiter
    // ================================================
    // First requester at or after the pointer wins
    always_comb begin
        int cand;
        rdGnt  = '0;
        gntIdx = '0;
        gntAny = 1'b0;
        for (int k = 0; k < numCore; k++) begin
            cand = int'(gntPtr) + k;
            if (cand >= numCore) begin
                cand = cand - numCore;
            end
            if (!gntAny && rdReq[cand]) begin
                gntAny      = 1'b1;
                gntIdx      = ptrWidth'(cand);
                rdGnt[cand] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            gntPtr <= '0;
        end else if (gntAny) begin
            // Winner drops to lowest priority
            gntPtr <= (gntIdx == ptrWidth'(numCore - 1)) ? '0 : gntIdx + 1'b1;
        end
    end

    // ================================================
    // Memory
    // ================================================
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrDat;
        end
        if (gntAny) begin
            rdDat <= mem[rdAddr[gntIdx]];
        end
    end

    // Valid lands on the granted core one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            rdDatVld <= '0;
        end else begin
            rdDatVld <= rdGnt;
        end
    end

endmodule

/* pointPoolPkg.sv */
// Shared widths, buffer depth and stream word layout, referenced by scoped name from every RTL file
package pointPoolPkg;

    // ================================================
    // Feature word
    // ================================================
    localparam int actWidth   = 8;
    localparam int numChannel = 8;
    localparam int wordWidth  = actWidth * numChannel;

    // ================================================
    // Neighbor map word
    // ================================================
    localparam int idxWidth    = 8;
    localparam int maxNeighbor = 7;
    // Count sits in whatever is left above the index fields
    localparam int countWidth  = wordWidth - maxNeighbor * idxWidth;

    // Feature buffer
    localparam int bufferDepth     = 64;
    localparam int bufferAddrWidth = $clog2(bufferDepth);

    // One stream word, read as features in the load phase and as a map in the map phase
    typedef union packed {
        logic [numChannel-1:0][actWidth-1:0] feature;
        struct packed {
            logic [countWidth-1:0]                count;
            logic [maxNeighbor-1:0][idxWidth-1:0] index;
        } map;
    } streamWord;

    // Round-robin pointer width over the pool cores, never below one bit
    function automatic int corePtrWidth(input int numCore);
        return (numCore > 1) ? $clog2(numCore) : 1;
    endfunction

endpackage
